// File: logic/battle_pkg.sv
package battle_pkg;

	localparam int board_dim = 5;
	localparam int coord_w = 3;
	localparam int addr_w = 6; // player bit followed by the cell index x*5+y

	// ship identifiers 1 to 5 sit between empty and hit, each equal to its ship's length
	typedef logic [2:0] cell_t;

	localparam cell_t cell_empty = 3'd0;
	localparam cell_t cell_hit = 3'd6;
	localparam cell_t cell_miss = 3'd7;

	typedef enum logic [2:0] {
		out_none,
		out_place_ok,
		out_place_reject,
		out_hit,
		out_miss,
		out_sunk,
		out_repeat
	} outcome_t;

	localparam logic [1:0] phase_place = 2'd0;
	localparam logic [1:0] phase_fire = 2'd1;
	localparam logic [1:0] phase_over = 2'd2;

endpackage

// File: logic/board_ram.sv
module board_ram (
	input logic clk,
	input logic reset,
	input logic mem_en,
	input logic mem_we,
	input logic [battle_pkg::addr_w-1:0] mem_addr,
	input battle_pkg::cell_t mem_wdata,
	output battle_pkg::cell_t rdata
);
	import battle_pkg::*;

	cell_t cells [0:2**addr_w-1]; // entries above 24 in each half are never addressed

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 2**addr_w; i++) begin
				cells[i] <= cell_empty;
			end
		end else if (mem_en) begin
			if (mem_we) begin
				cells[mem_addr] <= mem_wdata;
			end else begin
				rdata <= cells[mem_addr]; // valid in the cycle after the grant
			end
		end
	end

endmodule

// File: logic/board_arbiter.sv
module board_arbiter (
	input logic clk,
	input logic reset,
	input logic place_req,
	input logic place_we,
	input logic [battle_pkg::addr_w-1:0] place_addr,
	input battle_pkg::cell_t place_wdata,
	input logic fire_req,
	input logic fire_we,
	input logic [battle_pkg::addr_w-1:0] fire_addr,
	input battle_pkg::cell_t fire_wdata,
	output logic place_gnt,
	output logic fire_gnt,
	output logic mem_en,
	output logic mem_we,
	output logic [battle_pkg::addr_w-1:0] mem_addr,
	output battle_pkg::cell_t mem_wdata
);

	logic last_fire; // high when the resolver won the last grant

	assign place_gnt = place_req && (!fire_req || last_fire);
	assign fire_gnt = fire_req && (!place_req || !last_fire);

	assign mem_en = place_gnt || fire_gnt;
	assign mem_we = fire_gnt ? fire_we : place_we;
	assign mem_addr = fire_gnt ? fire_addr : place_addr;
	assign mem_wdata = fire_gnt ? fire_wdata : place_wdata;

	always_ff @(posedge clk) begin
		if (reset) begin
			last_fire <= 1'b0;
		end else if (place_gnt) begin
			last_fire <= 1'b0;
		end else if (fire_gnt) begin
			last_fire <= 1'b1;
		end
	end

endmodule

// File: logic/ship_placer.sv
module ship_placer #(
	parameter int ship_count = 3
) (
	input logic clk,
	input logic reset,
	input logic enable,
	input logic player,
	input logic [battle_pkg::coord_w-1:0] x,
	input logic [battle_pkg::coord_w-1:0] y,
	input logic confirm,
	input logic gnt,
	input battle_pkg::cell_t rdata,
	output logic req,
	output logic we,
	output logic [battle_pkg::addr_w-1:0] addr,
	output battle_pkg::cell_t wdata,
	output logic [2:0] placed_count,
	output logic place_ok,
	output logic place_reject,
	output logic all_placed
);
	import battle_pkg::*;

	localparam int idx_w = addr_w - 1;

	typedef enum logic [1:0] {st_idle, st_read, st_wait, st_write} state_t;

	state_t state;
	logic [coord_w-1:0] x_q;
	logic [coord_w-1:0] y_q;
	logic [2:0] step;
	logic player_q;
	logic [2:0] count_now;
	logic [2:0] ship_len;
	logic [3:0] ship_end;
	logic [idx_w-1:0] cell_idx;

	// a new player starts from zero even before the stored count has cleared
	assign count_now = (player != player_q) ? 3'd0 : placed_count;
	assign ship_len = count_now + 3'd1;
	assign ship_end = {1'b0, y} + {1'b0, ship_len};
	assign cell_idx = idx_w'(x_q) * idx_w'(board_dim) + idx_w'(y_q) + idx_w'(step);

	assign req = (state == st_read) || (state == st_write);
	assign we = (state == st_write);
	assign addr = {player, cell_idx};
	assign wdata = ship_len; // the identifier is the length

	always_ff @(posedge clk) begin
		place_ok <= 1'b0;
		place_reject <= 1'b0;
		all_placed <= 1'b0;
		if (reset) begin
			state <= st_idle;
			step <= 3'd0;
			placed_count <= 3'd0;
			player_q <= 1'b0;
		end else begin
			player_q <= player;
			if (player != player_q) begin
				placed_count <= 3'd0;
			end
			case (state)
				st_idle: begin
					if (enable && confirm && count_now < ship_count) begin
						x_q <= x;
						y_q <= y;
						step <= 3'd0;
						if (x >= board_dim || ship_end > board_dim) begin
							place_reject <= 1'b1; // ship would run off the board
						end else begin
							state <= st_read;
						end
					end
				end
				st_read: begin
					if (gnt) begin
						state <= st_wait;
					end
				end
				st_wait: begin
					if (rdata != cell_empty) begin
						place_reject <= 1'b1; // overlaps a ship already down
						state <= st_idle;
					end else if (step == ship_len - 3'd1) begin
						step <= 3'd0;
						state <= st_write;
					end else begin
						step <= step + 3'd1;
						state <= st_read;
					end
				end
				st_write: begin
					if (gnt) begin
						if (step == ship_len - 3'd1) begin
							placed_count <= ship_len;
							place_ok <= 1'b1;
							all_placed <= (ship_len == ship_count);
							state <= st_idle;
						end else begin
							step <= step + 3'd1;
						end
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

// File: logic/shot_resolver.sv
module shot_resolver #(
	parameter int ship_count = 3
) (
	input logic clk,
	input logic reset,
	input logic enable,
	input logic shooter,
	input logic [battle_pkg::coord_w-1:0] x,
	input logic [battle_pkg::coord_w-1:0] y,
	input logic confirm,
	input logic gnt,
	input battle_pkg::cell_t rdata,
	output logic req,
	output logic we,
	output logic [battle_pkg::addr_w-1:0] addr,
	output battle_pkg::cell_t wdata,
	output logic shot_done,
	output logic shot_hit,
	output logic shot_miss,
	output logic shot_sunk,
	output logic shot_repeat
);
	import battle_pkg::*;

	localparam int idx_w = addr_w - 1;

	typedef enum logic [1:0] {st_idle, st_read, st_wait, st_write} state_t;

	state_t state;
	logic [coord_w-1:0] x_q;
	logic [coord_w-1:0] y_q;
	cell_t target_q;
	logic [2:0] hit_cnt [0:1][1:ship_count]; // hits landed by each shooter on each ship
	logic [idx_w-1:0] cell_idx;

	assign cell_idx = idx_w'(x_q) * idx_w'(board_dim) + idx_w'(y_q);

	assign req = (state == st_read) || (state == st_write);
	assign we = (state == st_write);
	assign addr = {~shooter, cell_idx}; // always the opponent's half
	assign wdata = (target_q == cell_empty) ? cell_miss : cell_hit;

	always_ff @(posedge clk) begin
		shot_done <= 1'b0;
		shot_hit <= 1'b0;
		shot_miss <= 1'b0;
		shot_sunk <= 1'b0;
		shot_repeat <= 1'b0;
		if (reset) begin
			state <= st_idle;
			for (int p = 0; p < 2; p++) begin
				for (int s = 1; s <= ship_count; s++) begin
					hit_cnt[p][s] <= 3'd0;
				end
			end
		end else begin
			case (state)
				st_idle: begin
					if (enable && confirm) begin
						x_q <= x;
						y_q <= y;
						if (x >= board_dim || y >= board_dim) begin
							shot_repeat <= 1'b1; // off-board shots count as invalid, turn is kept
						end else begin
							state <= st_read;
						end
					end
				end
				st_read: begin
					if (gnt) begin
						state <= st_wait;
					end
				end
				st_wait: begin
					if (rdata == cell_hit || rdata == cell_miss) begin
						shot_repeat <= 1'b1;
						state <= st_idle;
					end else begin
						target_q <= rdata;
						state <= st_write;
					end
				end
				st_write: begin
					if (gnt) begin
						shot_done <= 1'b1;
						state <= st_idle;
						if (target_q == cell_empty) begin
							shot_miss <= 1'b1;
						end else begin
							shot_hit <= 1'b1;
							if (target_q <= ship_count) begin
								hit_cnt[shooter][target_q] <= hit_cnt[shooter][target_q] + 3'd1;
								shot_sunk <= (hit_cnt[shooter][target_q] + 3'd1 == target_q);
							end
						end
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

// File: logic/game_control.sv
module game_control #(
	parameter int ship_count = 3
) (
	input logic clk,
	input logic reset,
	input logic all_placed,
	input logic shot_done,
	input logic shot_hit,
	output logic [1:0] phase,
	output logic player,
	output logic place_en,
	output logic fire_en,
	output logic game_over,
	output logic winner
);
	import battle_pkg::*;

	localparam int total_cells = ship_count * (ship_count + 1) / 2;

	logic [3:0] hits [0:1];
	logic [1:0] phase_next;
	logic last_hit;

	assign last_hit = (phase == phase_fire) && shot_done && shot_hit &&
		(hits[player] + 4'd1 == total_cells);

	always_comb begin
		phase_next = phase;
		case (phase)
			phase_place: begin
				if (all_placed && player) begin
					phase_next = phase_fire; // both fleets are down
				end
			end
			phase_fire: begin
				if (last_hit) begin
					phase_next = phase_over;
				end
			end
			default: phase_next = phase;
		endcase
	end

	assign game_over = (phase == phase_over);

	always_ff @(posedge clk) begin
		if (reset) begin
			phase <= phase_place;
			player <= 1'b0;
			place_en <= 1'b0;
			fire_en <= 1'b0;
			winner <= 1'b0;
			hits[0] <= 4'd0;
			hits[1] <= 4'd0;
		end else begin
			phase <= phase_next;
			place_en <= (phase_next == phase_place);
			fire_en <= (phase_next == phase_fire);
			if (phase == phase_place && all_placed) begin
				player <= ~player; // player 1 places next, or player 0 opens fire
			end
			if (phase == phase_fire && shot_done) begin
				player <= ~player;
				if (shot_hit) begin
					hits[player] <= hits[player] + 4'd1;
				end
			end
			if (last_hit) begin
				winner <= player;
			end
		end
	end

endmodule

// File: logic/battle_top.sv
module battle_top (
	input logic clk,
	input logic reset,
	input logic [battle_pkg::coord_w-1:0] x,
	input logic [battle_pkg::coord_w-1:0] y,
	input logic confirm,
	output logic [1:0] phase,
	output logic turn,
	output logic place_ok,
	output logic place_reject,
	output logic shot_hit,
	output logic shot_miss,
	output logic shot_sunk,
	output logic shot_repeat,
	output logic game_over,
	output logic winner
);
	import battle_pkg::*;

	localparam int ship_count = 3;

	logic place_en;
	logic fire_en;
	logic all_placed;
	logic shot_done;
	logic place_req;
	logic place_we;
	logic [addr_w-1:0] place_addr;
	cell_t place_wdata;
	logic place_gnt;
	logic fire_req;
	logic fire_we;
	logic [addr_w-1:0] fire_addr;
	cell_t fire_wdata;
	logic fire_gnt;
	logic mem_en;
	logic mem_we;
	logic [addr_w-1:0] mem_addr;
	cell_t mem_wdata;
	cell_t rdata;

	game_control #(.ship_count(ship_count)) u_control (
		.clk(clk), .reset(reset), .all_placed(all_placed), .shot_done(shot_done),
		.shot_hit(shot_hit), .phase(phase), .player(turn), .place_en(place_en),
		.fire_en(fire_en), .game_over(game_over), .winner(winner)
	);

	ship_placer #(.ship_count(ship_count)) u_placer (
		.clk(clk), .reset(reset), .enable(place_en), .player(turn), .x(x), .y(y),
		.confirm(confirm), .gnt(place_gnt), .rdata(rdata), .req(place_req),
		.we(place_we), .addr(place_addr), .wdata(place_wdata), .placed_count(),
		.place_ok(place_ok), .place_reject(place_reject), .all_placed(all_placed)
	);

	shot_resolver #(.ship_count(ship_count)) u_resolver (
		.clk(clk), .reset(reset), .enable(fire_en), .shooter(turn), .x(x), .y(y),
		.confirm(confirm), .gnt(fire_gnt), .rdata(rdata), .req(fire_req),
		.we(fire_we), .addr(fire_addr), .wdata(fire_wdata), .shot_done(shot_done),
		.shot_hit(shot_hit), .shot_miss(shot_miss), .shot_sunk(shot_sunk),
		.shot_repeat(shot_repeat)
	);

	board_arbiter u_arbiter (
		.clk(clk), .reset(reset),
		.place_req(place_req), .place_we(place_we), .place_addr(place_addr),
		.place_wdata(place_wdata), .fire_req(fire_req), .fire_we(fire_we),
		.fire_addr(fire_addr), .fire_wdata(fire_wdata), .place_gnt(place_gnt),
		.fire_gnt(fire_gnt), .mem_en(mem_en), .mem_we(mem_we), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata)
	);

	board_ram u_ram (
		.clk(clk), .reset(reset), .mem_en(mem_en), .mem_we(mem_we),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata), .rdata(rdata)
	);

endmodule

// File: verif/battle_tb.sv
module battle_tb;
	import battle_pkg::*;

	localparam int clk_period = 8;
	localparam int reset_cycles = 10;
	localparam int response_limit = 100;
	localparam int quiet_cycles = 20;

	logic clk;
	logic reset;
	logic [coord_w-1:0] x;
	logic [coord_w-1:0] y;
	logic confirm;
	logic [1:0] phase;
	logic turn;
	logic place_ok;
	logic place_reject;
	logic shot_hit;
	logic shot_miss;
	logic shot_sunk;
	logic shot_repeat;
	logic game_over;
	logic winner;

	int tr_x[$];
	int tr_y[$];
	int tr_out[$];
	int tr_chk[$];
	int tr_phase[$];
	int tr_turn[$];
	int tr_over[$];
	int tr_win[$];
	int errors;
	int missing;
	int cycles;
	int cycle_limit;

	battle_top u_dut (
		.clk(clk), .reset(reset), .x(x), .y(y), .confirm(confirm),
		.phase(phase), .turn(turn), .place_ok(place_ok), .place_reject(place_reject),
		.shot_hit(shot_hit), .shot_miss(shot_miss), .shot_sunk(shot_sunk),
		.shot_repeat(shot_repeat), .game_over(game_over), .winner(winner)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// folds the outcome pulses of the current cycle into one trace code and gives -1 for a mixture
	function automatic int outcome_code();
		int kinds;
		kinds = int'(place_ok) + int'(place_reject) + int'(shot_hit) + int'(shot_miss) +
			int'(shot_repeat);
		if (kinds > 1 || (shot_sunk && !shot_hit)) return -1; // only sunk may join a hit
		if (place_ok) return int'(out_place_ok);
		if (place_reject) return int'(out_place_reject);
		if (shot_hit && shot_sunk) return int'(out_sunk);
		if (shot_hit) return int'(out_hit);
		if (shot_miss) return int'(out_miss);
		if (shot_repeat) return int'(out_repeat);
		return int'(out_none);
	endfunction

	task automatic load_trace(output bit ok);
		int fd;
		int n;
		int v[8];
		string line;
		ok = 1'b0;
		fd = $fopen("verif/battle_trace.txt", "r");
		if (fd != 0) begin
			ok = 1'b1;
			while ($fgets(line, fd) != 0) begin
				if (line.len() > 0 && line.getc(0) != "#") begin
					n = $sscanf(line, "%d %d %d %d %d %d %d %d",
						v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
					if (n == 8) begin
						tr_x.push_back(v[0]);
						tr_y.push_back(v[1]);
						tr_out.push_back(v[2]);
						tr_chk.push_back(v[3]);
						tr_phase.push_back(v[4]);
						tr_turn.push_back(v[5]);
						tr_over.push_back(v[6]);
						tr_win.push_back(v[7]);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic send_confirm(input int cx, input int cy);
		@(posedge clk);
		x <= coord_w'(cx);
		y <= coord_w'(cy);
		confirm <= 1'b1;
		@(posedge clk);
		confirm <= 1'b0;
	endtask

	task automatic await_outcome(output int got, output bit seen);
		int waited;
		got = int'(out_none);
		seen = 1'b0;
		waited = 0;
		while (!seen && waited < response_limit) begin
			@(negedge clk);
			waited++;
			got = outcome_code();
			seen = (got != int'(out_none));
		end
	endtask

	task automatic check_state(input int i);
		assert (phase == tr_phase[i]) else begin
			errors++;
			$display("Error at %0t: line %0d phase %0d, expected %0d", $time, i, phase,
				tr_phase[i]);
		end
		assert (turn == tr_turn[i]) else begin
			errors++;
			$display("Error at %0t: line %0d turn %0d, expected %0d", $time, i, turn,
				tr_turn[i]);
		end
		assert (game_over == tr_over[i]) else begin
			errors++;
			$display("Error at %0t: line %0d game_over %0d, expected %0d", $time, i, game_over,
				tr_over[i]);
		end
		assert (winner == tr_win[i]) else begin
			errors++;
			$display("Error at %0t: line %0d winner %0d, expected %0d", $time, i, winner,
				tr_win[i]);
		end
	endtask

	initial begin
		int got;
		bit seen;
		bit ok;
		reset = 1'b1;
		x = '0;
		y = '0;
		confirm = 1'b0;
		errors = 0;
		missing = 0;
		load_trace(ok);
		if (!ok || tr_x.size() == 0) begin
			$display("Could not read any action from the trace file verif/battle_trace.txt");
			$display("Test FAILED");
		end else begin
			cycle_limit = 100 * tr_x.size() + 50;
			repeat (reset_cycles) @(posedge clk);
			reset <= 1'b0;
			for (int i = 0; i < tr_x.size(); i++) begin
				send_confirm(tr_x[i], tr_y[i]);
				if (tr_out[i] == int'(out_none)) begin
					repeat (quiet_cycles) begin // nothing may answer once the game is over
						@(negedge clk);
						got = outcome_code();
						assert (got == int'(out_none)) else begin
							errors++;
							$display("Error at %0t: line %0d unexpected outcome %0d",
								$time, i, got);
						end
					end
				end else begin
					await_outcome(got, seen);
					assert (seen) else begin
						missing++;
						$display("Missing response: line %0d got no outcome pulse in %0d cycles",
							i, response_limit);
					end
					if (seen) begin
						assert (got == tr_out[i]) else begin
							errors++;
							$display("Error at %0t: line %0d outcome %0d, expected %0d",
								$time, i, got, tr_out[i]);
						end
					end
				end
				if (tr_chk[i] != 0) begin
					repeat (2) @(negedge clk); // game_control reacts one cycle after the pulse
					check_state(i);
				end
			end
			$display("Ran %0d trace lines: %0d wrong values, %0d missing responses", tr_x.size(),
				errors, missing);
			if (errors == 0 && missing == 0) begin
				$display("Test OK");
			end else begin
				$display("Test FAILED");
			end
		end
		$finish;
	end

	initial begin
		cycles = 0;
		wait (cycle_limit > 0);
		while (cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout after %0d cycles: %0d wrong values, %0d missing responses",
			cycle_limit, errors, missing);
		$display("Test FAILED");
		$finish;
	end

endmodule

// File: verif/battle_trace.txt
# x y outcome check phase turn game_over winner
# outcome 0 none 1 place_ok 2 place_reject 3 hit 4 miss 5 hit with sunk 6 repeat, check 1 compares the state columns
0 0 1 1 0 0 0 0
3 4 2 0 0 0 0 0
0 0 2 0 0 0 0 0
1 0 1 1 0 0 0 0
1 1 2 0 0 0 0 0
2 0 1 1 0 1 0 0
5 0 2 1 0 1 0 0
4 4 1 0 0 1 0 0
3 3 1 0 0 1 0 0
3 2 2 0 0 1 0 0
0 2 1 1 1 0 0 0
4 4 5 1 1 1 0 0
4 4 4 1 1 0 0 0
3 3 3 1 1 1 0 0
0 0 5 1 1 0 0 0
3 3 6 1 1 0 0 0
1 1 4 1 1 1 0 0
1 0 3 1 1 0 0 0
3 4 5 1 1 1 0 0
1 0 6 1 1 1 0 0
4 0 4 1 1 0 0 0
0 2 3 1 1 1 0 0
3 3 4 1 1 0 0 0
0 3 3 1 1 1 0 0
2 4 4 1 1 0 0 0
0 4 5 1 2 1 1 0
1 2 0 1 2 1 1 0

// File: compile.f
logic/battle_pkg.sv
logic/board_ram.sv
logic/board_arbiter.sv
logic/ship_placer.sv
logic/shot_resolver.sv
logic/game_control.sv
logic/battle_top.sv
verif/battle_tb.sv

// File: Bender.yml
package:
  name: battle

sources:
  - logic/battle_pkg.sv
  - logic/board_ram.sv
  - logic/board_arbiter.sv
  - logic/ship_placer.sv
  - logic/shot_resolver.sv
  - logic/game_control.sv
  - logic/battle_top.sv
  - target: test
    files:
      - verif/battle_tb.sv
